// ==== verilog.f ====
rtl/accel_pkg.sv
rtl/rate_strobe.sv
rtl/tag_queue.sv
rtl/spi_burst_engine.sv
rtl/channel_replay.sv
rtl/accel_reader_top.sv
tests/sensor_miso_model.sv
tests/accel_reader_props.sv
tests/tb_accel_reader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_accel_reader
FILELIST  ?= verilog.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run check clean

all: check

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)

check: run
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tests/tb_accel_reader.sv ====
// ####################################################################
// testbench for the dual accelerometer burst reader
// random bursts checked against a write sequence and tag queue model
// ####################################################################

module tb_accel_reader;
  timeunit 1ns;
  timeprecision 100ps;
  import accel_pkg::*;

  localparam int  rate_div = 4;
  localparam real wd_limit = 40.0 * (10 * 16 + 8) * rate_div * 8.0 + 100000.0;

  logic        clk;
  logic        rst_n;
  logic        auto_en;
  logic        sync;
  burst_req_t  req;
  spi_mode_t   mode;
  logic        direct;
  logic        direct_en;
  spi_pins_t   host;
  spi_pins_t   adxl;
  logic        miso0;
  logic        miso1;
  logic        tag_pulse;
  logic        tag_en;
  tag_t        tag;
  ram_wr_t     ram;
  logic [79:0] tx0;                              // sensor byte streams
  logic [79:0] tx1;
  byte_t       cmd0;
  byte_t       cmd1;

  integer seed = 32'h7d22c3e2;
  byte_t  got_q[$];                              // written bytes of the current burst
  tag_t   tq[$];                                 // tag FIFO model
  bit     pulse_m = 1'b0;
  bit     clr_open = 1'b0;
  tag_t   exp_char;
  len_t   cur_len;

  accel_reader_top #(.tag_enable(1'b1), .tag_addr_bits(4), .rate_div(rate_div),
    .max_len(10)) DUT (
    .clk(clk), .rst_n(rst_n), .auto_en(auto_en), .sync(sync), .req(req), .mode(mode),
    .direct(direct), .direct_en(direct_en), .host(host), .adxl(adxl), .miso0(miso0),
    .miso1(miso1), .tag_pulse(tag_pulse), .tag_en(tag_en), .tag(tag), .ram(ram)
  );

  sensor_miso_model u_sensor0 (.csn(adxl.csn), .sclk(adxl.sclk), .mosi(adxl.mosi),
    .mode(mode), .tx(tx0), .miso(miso0), .cmd_rx(cmd0));
  sensor_miso_model u_sensor1 (.csn(adxl.csn), .sclk(adxl.sclk), .mosi(adxl.mosi),
    .mode(mode), .tx(tx1), .miso(miso1), .cmd_rx(cmd1));

  bind spi_burst_engine accel_reader_props u_props (.clk(clk), .rst_n(rst_n),
    .state(state), .csn(csn_q), .direct_en(direct_en), .wr_port(ch0_wr));

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;                       // 8 ns period
  end

  task automatic stop_on_error();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp)
    begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp)
    begin
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  initial
  begin
    #(wd_limit);
    $display("watchdog expired, the DUT stopped producing the expected writes");
    stop_on_error();
  end

  // write port monitor, sampled mid cycle
  always @(negedge clk)
  begin
    if (rst_n)
    begin
      if (ram.clr)
      begin
        if (clr_open)
        begin
          $display("a clear arrived before the previous burst was fully written");
          stop_on_error();
        end
        clr_open = 1'b1;
      end
      if (ram.wr)
      begin
        if (!clr_open)
        begin
          $display("a write arrived without a clear before it");
          stop_on_error();
        end
        got_q.push_back(ram.data);
      end
    end
  end

  // character a pop returns: pulse first, then queue head, else space
  function automatic tag_t next_char();
    if (pulse_m)
    begin
      pulse_m = 1'b0;
      return tag_pulse_char;
    end
    if (tq.size() > 0)
      return tq.pop_front();
    return tag_idle_char;
  endfunction

  // data byte d (1 based) carries one tag bit when d is 2, 4 or 6
  function automatic byte_t stamp(input byte_t b, input int d, input tag_t c, input bit ch1);
    byte_t r;
    r = b;
    if ((d % 2 == 0) && (d >= 2) && (d <= 6))
      r[0] = ch1 ? c[d / 2 + 2] : c[d / 2 - 1];
    return r;
  endfunction

  task automatic push_tags();
    int cnt;
    cnt = $unsigned($random(seed)) % 4;
    repeat (cnt)
    begin
      tag    = tag_t'($random(seed));
      tag_en = 1'b1;
      if (tq.size() == 15)
        void'(tq.pop_front());                   // overflow drops the oldest
      tq.push_back(tag);
      @(posedge clk);
      #1;
      tag_en = 1'b0;
    end
  endtask

  task automatic start_burst(input len_t len, input bit pulse);
    req      = '{cmd: byte_t'($random(seed)), len: len};
    mode     = spi_mode_t'($random(seed));
    tx0      = {16'($random(seed)), $random(seed), $random(seed)};
    tx1      = {16'($random(seed)), $random(seed), $random(seed)};
    exp_char = next_char();
    cur_len  = len;
    if (pulse)
    begin
      sync = 1'b1;
      @(posedge clk);
      #1;
      sync = 1'b0;
    end
  endtask

  task automatic finish_burst();
    int   nd;
    tag_t dec;
    nd = int'(cur_len) - 1;
    while (got_q.size() < 2 * nd)
      @(negedge clk);
    clr_open = 1'b0;
    if (nd >= 6)
    begin
      for (int i = 0; i < 3; i++)
      begin
        dec[i]     = got_q[2 * i + 1][0];        // data byte 2i+2 on channel 0
        dec[i + 3] = got_q[nd + 2 * i + 1][0];
      end
      check_tag("tag_char", dec, exp_char);
    end
    for (int d = 1; d <= nd; d++)
    begin
      check_byte("ram.data ch0", got_q[d - 1], stamp(tx0[79 - 8 * (d - 1) -: 8], d, exp_char, 0));
      check_byte("ram.data ch1", got_q[nd + d - 1],
                 stamp(tx1[79 - 8 * (d - 1) -: 8], d, exp_char, 1));
    end
    check_byte("mosi cmd sensor0", cmd0, req.cmd);
    check_byte("mosi cmd sensor1", cmd1, req.cmd);
    got_q.delete();
    repeat (8) @(posedge clk);                   // engine drain tick
    #1;
  endtask

  initial
  begin
    rst_n     = 1'b0;
    auto_en   = 1'b0;
    sync      = 1'b0;
    req       = '{cmd: 8'h00, len: 4'd2};
    mode      = '{cpha: 1'b0, cpol: 1'b0};
    direct    = 1'b0;
    host      = '{csn: 1'b1, sclk: 1'b0, mosi: 1'b0};
    tag_pulse = 1'b0;
    tag_en    = 1'b0;
    tag       = '0;
    tx0       = '0;
    tx1       = '0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // plain bursts, empty queue stamps space bits
    repeat (10)
    begin
      start_burst(len_t'(2 + $unsigned($random(seed)) % 9), 1'b1);
      finish_burst();
    end

    // queued tags, long enough to carry all six bits
    repeat (6)
    begin
      push_tags();
      start_burst(len_t'(7 + $unsigned($random(seed)) % 4), 1'b1);
      finish_burst();
    end

    // pulse beats the queue once, then the head comes back
    tag    = 6'h15;
    tag_en = 1'b1;
    tq.push_back(tag);
    @(posedge clk);
    #1;
    tag_en    = 1'b0;
    tag_pulse = 1'b1;
    pulse_m   = 1'b1;
    @(posedge clk);
    #1;
    tag_pulse = 1'b0;
    start_burst(4'd10, 1'b1);
    finish_burst();
    start_burst(4'd10, 1'b1);
    finish_burst();

    // direct request in the middle of a burst
    start_burst(4'd10, 1'b1);
    repeat (40) @(posedge clk);
    #1;
    direct = 1'b1;
    @(negedge clk);
    while (got_q.size() < int'(cur_len))
    begin
      check_bit("direct_en", direct_en, 1'b0);   // held off through the chip select cycle
      @(negedge clk);
    end
    finish_burst();
    while (!direct_en)
      @(negedge clk);
    @(posedge clk);
    #1;
    repeat (10)
    begin
      host = spi_pins_t'($random(seed));
      @(negedge clk);
      check_bit("adxl.csn", adxl.csn, host.csn);
      check_bit("adxl.sclk", adxl.sclk, host.sclk);
      check_bit("adxl.mosi", adxl.mosi, host.mosi);
      @(posedge clk);
      #1;
    end
    sync = 1'b1;
    @(posedge clk);
    #1;
    sync = 1'b0;
    repeat (200) @(posedge clk);
    #1;
    if (got_q.size() != 0)
    begin
      $display("sync in direct mode produced RAM writes");
      stop_on_error();
    end
    host   = '{csn: 1'b1, sclk: 1'b0, mosi: 1'b0};
    direct = 1'b0;
    while (direct_en)
      @(negedge clk);
    @(posedge clk);
    #1;
    start_burst(len_t'(2 + $unsigned($random(seed)) % 9), 1'b1);
    finish_burst();

    // internal periodic sync
    for (int b = 0; b < 3; b++)
    begin
      start_burst(4'd8, 1'b0);
      auto_en = 1'b1;
      finish_burst();
    end
    auto_en = 1'b0;

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== tests/accel_reader_props.sv ====
// ####################################################################
// burst engine assertions, bound into spi_burst_engine
// ####################################################################

module accel_reader_props (
  input logic                    clk,
  input logic                    rst_n,
  input accel_pkg::burst_state_e state,
  input logic                    csn,            // engine chip select before the mux
  input logic                    direct_en,
  input accel_pkg::ram_wr_t      wr_port
);
  timeunit 1ns;
  timeprecision 100ps;
  import accel_pkg::*;

  logic clr_pending;                             // clr seen, no wr yet

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      clr_pending <= 1'b0;
    else if (wr_port.clr)
      clr_pending <= 1'b1;
    else if (wr_port.wr)
      clr_pending <= 1'b0;
  end

  a_wr_clr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_port.wr && wr_port.clr)) else $error("wr and clr high together");

  a_csn_direct: assert property (@(posedge clk) disable iff (!rst_n)
    direct_en |-> csn) else $error("engine chip select low while direct is granted");

  a_grant_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(direct_en) |-> ($past(state) == idle)) else $error("direct grant moved in a burst");

  a_clr_then_wr: assert property (@(posedge clk) disable iff (!rst_n)
    !(clr_pending && $rose(csn))) else $error("chip select rose before a write followed clr");

endmodule

// ==== tests/sensor_miso_model.sv ====
// ####################################################################
// SPI slave model, shifts a preset byte stream out on miso and
// captures the first mosi byte of each chip select cycle
// ####################################################################

module sensor_miso_model (
  input  logic                 csn,
  input  logic                 sclk,
  input  logic                 mosi,
  input  accel_pkg::spi_mode_t mode,
  input  logic [79:0]          tx,               // data byte 0 in the top bits
  output logic                 miso,
  output accel_pkg::byte_t     cmd_rx
);
  timeunit 1ns;
  timeprecision 100ps;
  import accel_pkg::*;

  int    n = 0;                                  // stream bit on miso
  int    rx_cnt = 0;
  byte_t rx_sr = 8'h00;
  logic  act;

  // bits 0..7 go out during the command byte, then data MSB first
  function automatic logic bit_at(input int k, input logic [79:0] v);
    if ((k < 8) || (k >= 88))
      return 1'b0;
    return v[79 - (k - 8)];
  endfunction

  assign act  = sclk ^ mode.cpol;
  assign miso = (csn || (n < 0)) ? 1'b0 : bit_at(n, tx);

  always @(negedge csn)
  begin
    n      = mode.cpha ? -1 : 0;                 // cpha 1 shifts before the first sample
    rx_cnt = 0;
  end

  always @(act)
  begin
    if (!csn)
    begin
      if (act ^ mode.cpha)
      begin
        if (rx_cnt < 8)
        begin
          rx_sr  = {rx_sr[6:0], mosi};
          rx_cnt = rx_cnt + 1;
          if (rx_cnt == 8)
            cmd_rx = rx_sr;
        end
      end
      else
        n = n + 1;                               // shift edge
    end
  end

endmodule

// ==== rtl/accel_reader_top.sv ====
// ####################################################################
// dual accelerometer burst reader, top level
// ####################################################################

module accel_reader_top #(
  parameter bit tag_enable    = 1'b0,
  parameter int tag_addr_bits = 4,
  parameter int rate_div      = 4,
  parameter int max_len       = 10
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  auto_en,         // internal periodic sync
  input  logic                  sync,
  input  accel_pkg::burst_req_t req,
  input  accel_pkg::spi_mode_t  mode,
  input  logic                  direct,
  output logic                  direct_en,
  input  accel_pkg::spi_pins_t  host,
  output accel_pkg::spi_pins_t  adxl,
  input  logic                  miso0,
  input  logic                  miso1,
  input  logic                  tag_pulse,
  input  logic                  tag_en,
  input  accel_pkg::tag_t       tag,
  output accel_pkg::ram_wr_t    ram
);
  import accel_pkg::*;

  logic    bit_en;
  logic    auto_sync;
  logic    start;
  logic    tag_pop;
  tag_t    tag_char;
  ram_wr_t ch0_wr;                               // streamed channel 0 writes
  byte_t   ch1_byte;
  logic    ch1_valid;
  logic    burst_done;
  logic    rep_wr;
  byte_t   rep_data;

  assign start = sync | auto_sync;

  rate_strobe #(.rate_div(rate_div)) u_rate (
    .clk(clk), .rst_n(rst_n), .auto_en(auto_en), .bit_en(bit_en), .auto_sync(auto_sync)
  );

  tag_queue #(.tag_addr_bits(tag_addr_bits)) u_tagq (
    .clk(clk), .rst_n(rst_n), .tag_pulse(tag_pulse), .tag_en(tag_en), .tag(tag),
    .pop(tag_pop), .tag_char(tag_char)
  );

  spi_burst_engine #(.tag_enable(tag_enable)) u_engine (
    .clk(clk), .rst_n(rst_n), .bit_en(bit_en), .start(start), .req(req), .mode(mode),
    .direct(direct), .direct_en(direct_en), .host(host), .adxl(adxl),
    .miso0(miso0), .miso1(miso1), .tag_char(tag_char), .tag_pop(tag_pop),
    .ch0_wr(ch0_wr), .ch1_byte(ch1_byte), .ch1_valid(ch1_valid), .burst_done(burst_done)
  );

  channel_replay #(.max_len(max_len)) u_replay (
    .clk(clk), .rst_n(rst_n), .ch1_valid(ch1_valid), .ch1_byte(ch1_byte),
    .burst_done(burst_done), .len(req.len), .rep_wr(rep_wr), .rep_data(rep_data)
  );

  // replay runs only after csn is high, so the two sources never collide
  assign ram = '{wr:   ch0_wr.wr | rep_wr,
                 clr:  ch0_wr.clr,
                 data: rep_wr ? rep_data : ch0_wr.data};

endmodule

// ==== rtl/channel_replay.sv ====
// ####################################################################
// channel 1 replay buffer, stores bytes during a burst and
// writes them out back to back once chip select has risen
// ####################################################################

module channel_replay #(
  parameter int max_len = 10                     // bytes kept per burst
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             ch1_valid,
  input  accel_pkg::byte_t ch1_byte,
  input  logic             burst_done,
  input  accel_pkg::len_t  len,
  output logic             rep_wr,
  output accel_pkg::byte_t rep_data
);
  import accel_pkg::*;

  localparam int aw = (max_len > 1) ? $clog2(max_len) : 1;

  byte_t         mem [max_len];
  logic [aw-1:0] wr_idx;
  logic [aw-1:0] rd_idx;
  logic [aw-1:0] last_idx;                       // index of final replay byte
  len_t          len_q;                          // length of the burst being stored

  assign last_idx = aw'(len_q - 4'd2);

  always_ff @(posedge clk)
  begin
    if (ch1_valid)
      mem[wr_idx] <= ch1_byte;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_idx <= '0;
      rd_idx <= '0;
      rep_wr <= 1'b0;
      len_q  <= 4'd0;
    end
    else
    begin
      if (burst_done)
        wr_idx <= '0;                            // next burst starts at slot 0
      else if (ch1_valid && (int'(wr_idx) < max_len - 1))
        wr_idx <= wr_idx + 1'b1;                 // extra bytes pile on the last slot
      if (ch1_valid && (wr_idx == '0))
        len_q <= len;
      if (burst_done && (wr_idx != '0) && (len_q >= 4'd2))
      begin
        rep_wr <= 1'b1;
        rd_idx <= '0;
      end
      else if (rep_wr)
      begin
        if (rd_idx == last_idx)
          rep_wr <= 1'b0;                        // len-1 clocks in total
        else
          rd_idx <= rd_idx + 1'b1;
      end
    end
  end

  assign rep_data = mem[rd_idx];

endmodule

// ==== rtl/spi_burst_engine.sv ====
// ####################################################################
// SPI burst sequencer for two sensors on one chip select
// cmd out, data in on both miso lines, tag stamping, direct host mux
// ####################################################################

module spi_burst_engine #(
  parameter bit tag_enable = 1'b0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bit_en,
  input  logic                  start,
  input  accel_pkg::burst_req_t req,
  input  accel_pkg::spi_mode_t  mode,
  input  logic                  direct,
  output logic                  direct_en,
  input  accel_pkg::spi_pins_t  host,
  output accel_pkg::spi_pins_t  adxl,
  input  logic                  miso0,
  input  logic                  miso1,
  input  accel_pkg::tag_t       tag_char,
  output logic                  tag_pop,
  output accel_pkg::ram_wr_t    ch0_wr,
  output accel_pkg::byte_t      ch1_byte,
  output logic                  ch1_valid,
  output logic                  burst_done
);
  import accel_pkg::*;

  burst_state_e state;
  burst_req_t   req_q;                           // cmd and len of running burst
  logic [7:0]   tick;                            // {byte slot, tick in slot}
  logic         csn_q;
  logic         sclk_act;                        // sclk before cpol is applied
  byte_t        mosi_sr;
  byte_t        miso0_sr;
  byte_t        miso1_sr;
  logic         wr_q;
  logic         clr_q;
  byte_t        data0_q;
  spi_pins_t    eng_pins;                        // own pins before the direct mux
  logic         go;
  logic         in_win;                          // sclk toggling window
  logic         byte_end;                        // last bit of a data byte sampled
  logic [3:0]   dnum;                            // data byte number, 1 = first
  logic         tag_hit;
  logic [1:0]   tag_i;
  byte_t        rx0;
  byte_t        rx1;

  // no burst while direct is requested or granted
  assign go       = (state == idle) && start && !direct && !direct_en;
  // bits run from tick 4 to len*16+3, even ticks shift, odd ticks sample
  assign in_win   = (tick >= 8'd4) && (tick < {req_q.len, 4'h4});
  assign byte_end = (state == active) && bit_en && in_win && (tick[3:0] == 4'h3)
                    && (tick[7:4] >= 4'd2);      // slot 1 ends the cmd byte
  assign dnum     = tick[7:4] - 4'd1;
  assign tag_hit  = tag_enable && !dnum[0] && (dnum >= 4'd2) && (dnum <= 4'd6);
  assign tag_i    = dnum[2:1] - 2'd1;            // bytes 2,4,6 carry bits 0,1,2
  assign rx0      = tag_hit ? {miso0_sr[6:0], tag_char[tag_i]}
                            : {miso0_sr[6:0], miso0};
  assign rx1      = tag_hit ? {miso1_sr[6:0], tag_char[3'(tag_i) + 3'd3]}
                            : {miso1_sr[6:0], miso1};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state      <= idle;
      tick       <= 8'd0;
      csn_q      <= 1'b1;
      sclk_act   <= 1'b0;
      mosi_sr    <= 8'h00;
      direct_en  <= 1'b0;
      tag_pop    <= 1'b0;
      burst_done <= 1'b0;
      wr_q       <= 1'b0;
      clr_q      <= 1'b0;
    end
    else
    begin
      tag_pop    <= 1'b0;
      burst_done <= 1'b0;
      wr_q       <= byte_end;                    // one clk after the final sample
      clr_q      <= (state == active) && bit_en && (tick == 8'd8) && (req_q.len >= 4'd2);
      case (state)
        idle:
        begin
          if (go)
          begin
            state   <= active;
            tick    <= 8'd0;
            tag_pop <= 1'b1;                     // char is ready long before byte 2
          end
          else
            direct_en <= direct;                 // grant moves only here
        end
        active:
        begin
          if (bit_en)
          begin
            tick     <= tick + 8'd1;
            sclk_act <= in_win & (tick[0] ^ mode.cpha);
            if (tick == 8'd0)
              csn_q <= 1'b0;
            if (in_win && !tick[0])
              mosi_sr <= (tick == 8'd4) ? req_q.cmd : {mosi_sr[6:0], 1'b0};
            if (tick == {req_q.len, 4'h5})
            begin
              csn_q      <= 1'b1;
              burst_done <= 1'b1;                // replay may start now
              state      <= drain;
            end
          end
        end
        drain:
        begin
          if (bit_en)
            state <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (go)
      req_q <= req;
    if ((state == active) && bit_en && in_win && tick[0])
    begin
      miso0_sr <= {miso0_sr[6:0], miso0};        // value just before the sample edge
      miso1_sr <= {miso1_sr[6:0], miso1};
    end
    if (byte_end)
    begin
      data0_q  <= rx0;
      ch1_byte <= rx1;
    end
  end

  assign ch1_valid = wr_q;
  assign ch0_wr    = '{wr: wr_q, clr: clr_q, data: data0_q};
  assign eng_pins  = '{csn: csn_q, sclk: sclk_act ^ mode.cpol, mosi: mosi_sr[7]};
  assign adxl      = direct_en ? host : eng_pins;

endmodule

// ==== rtl/tag_queue.sv ====
// ####################################################################
// tag character queue, pulse tag wins over FIFO, space when empty
// ####################################################################

module tag_queue #(
  parameter int tag_addr_bits = 4                // FIFO depth is 2**n
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            tag_pulse,
  input  logic            tag_en,
  input  accel_pkg::tag_t tag,
  input  logic            pop,
  output accel_pkg::tag_t tag_char
);
  import accel_pkg::*;

  localparam int depth = 2 ** tag_addr_bits;

  tag_t                     mem [depth];         // character storage
  logic [tag_addr_bits-1:0] wptr;
  logic [tag_addr_bits-1:0] rptr;
  logic [tag_addr_bits-1:0] wnext;
  logic                     pulse_flag;          // sticky, set by tag_pulse
  logic                     empty;
  logic                     full;
  logic                     rd_adv;              // head consumed by a pop
  logic                     drop;                // push into full queue

  assign wnext  = wptr + 1'b1;
  assign empty  = (wptr == rptr);
  assign full   = (wnext == rptr);               // one slot kept free
  assign rd_adv = pop && !pulse_flag && !empty;
  assign drop   = tag_en && full;                // oldest entry gets lost

  always_ff @(posedge clk)
  begin
    if (tag_en)
      mem[wptr] <= tag;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wptr       <= '0;
      rptr       <= '0;
      pulse_flag <= 1'b0;
      tag_char   <= tag_idle_char;
    end
    else
    begin
      if (tag_en)
        wptr <= wnext;
      if (rd_adv || drop)
        rptr <= rptr + 1'b1;                     // pop and overflow never stack
      if (pop && pulse_flag)
        pulse_flag <= 1'b0;
      if (tag_pulse)
        pulse_flag <= 1'b1;                      // a new pulse beats a same-cycle pop
      if (pop)
      begin
        if (pulse_flag)
          tag_char <= tag_pulse_char;            // queue keeps its content
        else if (empty)
          tag_char <= tag_idle_char;
        else
          tag_char <= mem[rptr];
      end
    end
  end

endmodule

// ==== rtl/rate_strobe.sv ====
// ####################################################################
// pace source: bit-rate enable from clk, periodic sync when auto is on
// ####################################################################

module rate_strobe #(
  parameter int rate_div = 4                     // clk cycles per bit_en
) (
  input  logic clk,
  input  logic rst_n,
  input  logic auto_en,
  output logic bit_en,
  output logic auto_sync
);

  localparam int cw = (rate_div > 1) ? $clog2(rate_div) : 1;

  logic [cw-1:0] div_cnt;                        // clk divider
  logic [7:0]    tick_cnt;                       // bit_en ticks, wraps every 256

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      div_cnt   <= '0;
      tick_cnt  <= 8'd0;
      bit_en    <= 1'b0;
      auto_sync <= 1'b0;
    end
    else
    begin
      bit_en <= (div_cnt == cw'(rate_div - 1)); // one clk wide
      if (div_cnt == cw'(rate_div - 1))
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;
      auto_sync <= 1'b0;
      if (bit_en)
      begin
        tick_cnt  <= tick_cnt + 8'd1;
        // 256 ticks covers the longest burst plus its drain tick
        auto_sync <= auto_en && (tick_cnt == 8'hff);
      end
    end
  end

endmodule

// ==== rtl/accel_pkg.sv ====
// ####################################################################
// accelerometer burst reader shared definitions
// widths, tag characters, pin and write port structs, sequencer states
// ####################################################################

package accel_pkg;

  localparam int tag_w = 6;                      // tag character width

  typedef logic [7:0]       byte_t;              // one SPI byte
  typedef logic [3:0]       len_t;               // burst length incl. command byte
  typedef logic [tag_w-1:0] tag_t;               // NMEA style 6-bit character

  localparam tag_t tag_pulse_char = 6'h21;       // "!" forced by a tag pulse
  localparam tag_t tag_idle_char  = 6'h20;       // space when the queue is empty

  // sensor side SPI pins, miso lines travel separately
  typedef struct packed {
    logic csn;                                   // chip select, active low
    logic sclk;
    logic mosi;
  } spi_pins_t;

  // clock shape, 0/0 for the ADXL355
  typedef struct packed {
    logic cpha;
    logic cpol;
  } spi_mode_t;

  // what to read, latched when a burst starts
  typedef struct packed {
    byte_t cmd;                                  // first byte on mosi
    len_t  len;                                  // bytes including cmd
  } burst_req_t;

  // buffer RAM write port
  typedef struct packed {
    logic  wr;                                   // one clk per byte
    logic  clr;                                  // address reset before first wr
    byte_t data;
  } ram_wr_t;

  typedef enum logic [1:0] {
    idle,                                        // waiting for start, direct may switch
    active,                                      // chip select cycle running
    drain                                        // one tick after csn rises
  } burst_state_e;

endpackage
